// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = dcache_tb
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/dcache_pkg.sv
package dcache_pkg;

    // ##############################
    // Geometry
    // ##############################

    typedef logic [31:0] data_word_t;                           // Data and address words are both 32 bits.

    localparam int BYTE_BITS      = 2;                          // Byte select below the word offset.
    localparam int OFFSET_BITS    = 2;                          // Word offset within a block.
    localparam int BLOCK_WORDS    = 1 << OFFSET_BITS;           // Four words per block.
    localparam int INDEX_BITS     = 4;                          // Set index.
    localparam int SETS           = 1 << INDEX_BITS;            // Sixteen sets, one line each.
    localparam int TAG_BITS       = 32 - INDEX_BITS - OFFSET_BITS - BYTE_BITS;

    localparam int MEM_WORDS      = 1024;                       // Depth of the main memory RAM.
    localparam int MEM_ADDR_BITS  = $clog2(MEM_WORDS);          // Addresses wrap modulo the depth.
    localparam int MEM_LATENCY    = 4;                          // Request to first load word.
    localparam int LOAD_COUNT_BITS = $clog2(MEM_LATENCY + BLOCK_WORDS);

    // ##############################
    // Address and array types
    // ##############################

    // The same request word is seen either whole or split into cache fields.
    typedef union packed {
        data_word_t raw;                                        // Address as issued by the core.
        struct packed {
            logic [TAG_BITS-1:0]    tag;
            logic [INDEX_BITS-1:0]  index;
            logic [OFFSET_BITS-1:0] offset;
            logic [BYTE_BITS-1:0]   byte_sel;                   // Always zero for word accesses.
        } fields;
    } cache_address_u;

    typedef struct packed {
        logic valid;                                            // Line holds a block.
        logic dirty;                                            // Line differs from memory.
    } status_packet_t;

    typedef struct packed {
        logic tag;
        logic status;
        logic data;
    } data_enable_t;

    // Everything a controller drives into the cache array.
    typedef struct packed {
        data_enable_t   read;
        data_enable_t   write;
        data_word_t     address;
        data_word_t     data;
        status_packet_t status;
    } cache_port_t;

    typedef struct packed {
        logic       request;                                    // One cycle per block load.
        data_word_t address;                                    // Block base address.
    } load_channel_t;

    typedef struct packed {
        logic       request;                                    // One cycle per word written.
        data_word_t address;
        data_word_t data;
    } store_channel_t;

endpackage : dcache_pkg

// File: load_controller/load_controller.sv
module load_controller
    import dcache_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  logic                request_i,
    input  data_word_t          address_i,
    output data_word_t          data_o,
    output logic                valid_o,

    input  logic                cache_hit_i,
    input  logic [TAG_BITS-1:0] cache_tag_i,
    input  logic                cache_dirty_i,
    input  data_word_t          cache_data_i,
    output cache_port_t         cache_port_o,

    output load_channel_t       load_channel_o,
    input  logic                load_valid_i,
    input  data_word_t          load_data_i,

    output store_channel_t      wb_channel_o,
    input  logic                wb_done_i
);

    // ##############################
    // Datapath
    // ##############################

    typedef enum logic [1:0] {IDLE, OUTCOME, WRITE_BACK, ALLOCATE} load_state_t;

    load_state_t              state_q, state_d;
    data_word_t               address_q;                        // Request address held for the whole miss.
    cache_address_u           request_addr;
    data_word_t               requested_q, requested_d;         // Requested word caught during allocation.
    logic [OFFSET_BITS:0]     counter_q, counter_d;             // Extra bit marks the end of a burst.
    logic [OFFSET_BITS-1:0]   wb_offset;

    assign request_addr.raw = address_q;

    // The word being stored lags the word being read by one.
    assign wb_offset = counter_q[OFFSET_BITS-1:0] - 1'b1;

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && request_i) begin
            address_q <= address_i;                             // The core holds the address for one cycle only.
        end
        requested_q <= requested_d;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            counter_q <= '0;
        end else begin
            state_q   <= state_d;
            counter_q <= counter_d;
        end
    end

    // ##############################
    // FSM
    // ##############################

    always_comb begin
        state_d     = state_q;
        counter_d   = counter_q;
        requested_d = requested_q;

        cache_port_o   = '0;
        load_channel_o = '0;
        wb_channel_o   = '0;
        data_o         = '0;
        valid_o        = 1'b0;

        // Block base of the requested line.
        load_channel_o.address = {request_addr.fields.tag, request_addr.fields.index,
                                  {OFFSET_BITS{1'b0}}, {BYTE_BITS{1'b0}}};

        // Victim words go back to the address of the line being evicted.
        wb_channel_o.address = {cache_tag_i, request_addr.fields.index, wb_offset,
                                {BYTE_BITS{1'b0}}};
        wb_channel_o.data    = cache_data_i;

        case (state_q)
            IDLE: begin
                cache_port_o.address = address_i;
                counter_d            = '0;
                if (request_i) begin
                    cache_port_o.read = '1;                     // Tag, status and data in one read.
                    state_d           = OUTCOME;
                end
            end

            OUTCOME: begin
                if (cache_hit_i) begin
                    data_o  = cache_data_i;                     // Hit data is forwarded straight away.
                    valid_o = 1'b1;
                    state_d = IDLE;
                end else if (cache_dirty_i) begin
                    // Start reading the victim from its first word.
                    cache_port_o.read.data = 1'b1;
                    cache_port_o.address  = {cache_tag_i, request_addr.fields.index,
                                             counter_q[OFFSET_BITS-1:0], {BYTE_BITS{1'b0}}};
                    counter_d              = counter_q + 1'b1;
                    state_d                = WRITE_BACK;
                end else begin
                    load_channel_o.request = 1'b1;              // A clean line is replaced without a write-back.
                    state_d                = ALLOCATE;
                end
            end

            WRITE_BACK: begin
                if (!counter_q[OFFSET_BITS] && counter_q[OFFSET_BITS-1:0] != '0) begin
                    // Read the next word while the previous one goes to memory.
                    cache_port_o.read.data = 1'b1;
                    cache_port_o.address  = {cache_tag_i, request_addr.fields.index,
                                             counter_q[OFFSET_BITS-1:0], {BYTE_BITS{1'b0}}};
                    wb_channel_o.request   = 1'b1;
                    counter_d              = counter_q + 1'b1;
                end else if (counter_q[OFFSET_BITS] && counter_q[OFFSET_BITS-1:0] == '0) begin
                    wb_channel_o.request = 1'b1;                // The last word needs no further read.
                    counter_d            = counter_q + 1'b1;
                end

                if (wb_done_i) begin
                    load_channel_o.request = 1'b1;              // The new block is fetched once the victim is in memory.
                    counter_d              = '0;
                    state_d                = ALLOCATE;
                end
            end

            ALLOCATE: begin
                cache_port_o.address = {request_addr.fields.tag, request_addr.fields.index,
                                        counter_q[OFFSET_BITS-1:0], {BYTE_BITS{1'b0}}};
                cache_port_o.data    = load_data_i;
                cache_port_o.status  = '{valid: 1'b1, dirty: 1'b0};

                if (load_valid_i) begin
                    cache_port_o.write.data = 1'b1;
                    counter_d               = counter_q + 1'b1;

                    if (counter_q[OFFSET_BITS-1:0] == '0) begin
                        cache_port_o.write = '1;                // Tag and status go in with the first word.
                    end

                    if (counter_q[OFFSET_BITS-1:0] == request_addr.fields.offset) begin
                        requested_d = load_data_i;
                    end

                    if (counter_q[OFFSET_BITS-1:0] == '1) begin
                        // The last word may itself be the requested one.
                        data_o  = (request_addr.fields.offset == '1) ? load_data_i : requested_q;
                        valid_o = 1'b1;
                        state_d = IDLE;
                    end
                end
            end

            default: state_d = IDLE;
        endcase
    end

endmodule : load_controller

// File: source/cache_memory.sv
module cache_memory
    import dcache_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  cache_port_t         port_i,

    output logic                hit_o,
    output logic [TAG_BITS-1:0] tag_o,
    output logic                dirty_o,
    output data_word_t          data_o
);

    // ##############################
    // Arrays
    // ##############################

    logic [TAG_BITS-1:0]             tag_array [SETS];
    status_packet_t                  status_array [SETS];
    data_word_t                      data_array [SETS * BLOCK_WORDS];

    cache_address_u                  port_addr;
    logic [INDEX_BITS+OFFSET_BITS-1:0] word_sel;                 // Set and offset pick one data word.

    logic [TAG_BITS-1:0]             tag_q;
    logic [TAG_BITS-1:0]             lookup_tag_q;               // Tag of the address that was read.
    status_packet_t                  status_q;
    data_word_t                      data_q;

    assign port_addr.raw = port_i.address;
    assign word_sel      = {port_addr.fields.index, port_addr.fields.offset};

    // Every line starts invalid and clean after reset.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < SETS; i++) begin
                status_array[i] <= '0;
            end
            status_q <= '0;
        end else begin
            if (port_i.write.status) begin
                status_array[port_addr.fields.index] <= port_i.status;
            end
            if (port_i.read.status) begin
                status_q <= status_array[port_addr.fields.index];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (port_i.write.tag) begin
            tag_array[port_addr.fields.index] <= port_addr.fields.tag;
        end
        if (port_i.write.data) begin
            data_array[word_sel] <= port_i.data;
        end

        // A data-only read keeps the tag, which a write-back still needs.
        if (port_i.read.tag) begin
            tag_q        <= tag_array[port_addr.fields.index];
            lookup_tag_q <= port_addr.fields.tag;
        end
        if (port_i.read.data) begin
            data_q <= data_array[word_sel];
        end
    end

    // ##############################
    // Lookup result
    // ##############################

    assign hit_o   = status_q.valid && (tag_q == lookup_tag_q);
    assign tag_o   = tag_q;
    assign dirty_o = status_q.dirty;
    assign data_o  = data_q;

endmodule : cache_memory

// File: source/dcache_top.sv
module dcache_top
    import dcache_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  logic       load_request_i,
    input  data_word_t load_address_i,
    output data_word_t load_data_o,
    output logic       load_valid_o,

    input  logic       store_request_i,
    input  data_word_t store_address_i,
    input  data_word_t store_data_i,
    output logic       store_done_o
);

    cache_port_t         load_port;                             // Load side request to the array.
    cache_port_t         cache_port;                            // Whatever reaches the array.
    logic                cache_hit;
    logic [TAG_BITS-1:0] cache_tag;
    logic                cache_dirty;
    data_word_t          cache_data;

    load_channel_t       load_channel;
    logic                mem_load_valid;
    data_word_t          mem_load_data;
    store_channel_t      wb_channel;
    logic                wb_done;
    store_channel_t      wt_channel;
    logic                wt_done;

    load_controller u_load_controller (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .request_i      (load_request_i),
        .address_i      (load_address_i),
        .data_o         (load_data_o),
        .valid_o        (load_valid_o),
        .cache_hit_i    (cache_hit),
        .cache_tag_i    (cache_tag),
        .cache_dirty_i  (cache_dirty),
        .cache_data_i   (cache_data),
        .cache_port_o   (load_port),
        .load_channel_o (load_channel),
        .load_valid_i   (mem_load_valid),
        .load_data_i    (mem_load_data),
        .wb_channel_o   (wb_channel),
        .wb_done_i      (wb_done)
    );

    store_controller u_store_controller (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .request_i    (store_request_i),
        .address_i    (store_address_i),
        .data_i       (store_data_i),
        .done_o       (store_done_o),
        .load_port_i  (load_port),
        .cache_port_o (cache_port),
        .cache_hit_i  (cache_hit),
        .wt_channel_o (wt_channel),
        .wt_done_i    (wt_done)
    );

    cache_memory u_cache_memory (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .port_i  (cache_port),
        .hit_o   (cache_hit),
        .tag_o   (cache_tag),
        .dirty_o (cache_dirty),
        .data_o  (cache_data)
    );

    memory_controller u_memory_controller (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .load_channel_i (load_channel),
        .load_valid_o   (mem_load_valid),
        .load_data_o    (mem_load_data),
        .wb_channel_i   (wb_channel),
        .wb_done_o      (wb_done),
        .wt_channel_i   (wt_channel),
        .wt_done_o      (wt_done)
    );

endmodule : dcache_top

// File: source/memory_controller.sv
module memory_controller
    import dcache_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,

    input  load_channel_t  load_channel_i,
    output logic           load_valid_o,
    output data_word_t     load_data_o,

    input  store_channel_t wb_channel_i,
    output logic           wb_done_o,

    input  store_channel_t wt_channel_i,
    output logic           wt_done_o
);

    data_word_t ram [MEM_WORDS];

    logic                                   load_active_q;
    logic [LOAD_COUNT_BITS-1:0]             load_count_q;       // Cycles since the load request.
    logic [MEM_ADDR_BITS-OFFSET_BITS-1:0]   block_q;            // Block number inside the RAM.
    logic [OFFSET_BITS-1:0]                 beat;
    logic [OFFSET_BITS-1:0]                 wb_count_q;         // Write-back words seen so far.

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            ram[i] = '0;
        end
    end

    // ##############################
    // Block loads
    // ##############################

    // Words leave one cycle after the count selects them.
    assign beat = OFFSET_BITS'(load_count_q - LOAD_COUNT_BITS'(MEM_LATENCY - 1));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            load_active_q <= 1'b0;
            load_count_q  <= '0;
            load_valid_o  <= 1'b0;
        end else begin
            load_valid_o <= 1'b0;
            if (load_channel_i.request) begin
                load_active_q <= 1'b1;
                load_count_q  <= LOAD_COUNT_BITS'(1);
            end else if (load_active_q) begin
                load_count_q <= load_count_q + 1'b1;
                if (load_count_q >= LOAD_COUNT_BITS'(MEM_LATENCY - 1)) begin
                    load_valid_o <= 1'b1;                       // One word per cycle, in offset order.
                end
                if (load_count_q == LOAD_COUNT_BITS'(MEM_LATENCY + BLOCK_WORDS - 2)) begin
                    load_active_q <= 1'b0;                      // The last beat is on its way.
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_channel_i.request) begin
            block_q <= load_channel_i.address[MEM_ADDR_BITS+1:OFFSET_BITS+2];
        end
        load_data_o <= ram[{block_q, beat}];
    end

    // ##############################
    // Writes
    // ##############################

    always_ff @(posedge clk_i) begin
        if (wb_channel_i.request) begin
            ram[wb_channel_i.address[MEM_ADDR_BITS+1:2]] <= wb_channel_i.data;
        end else if (wt_channel_i.request) begin
            ram[wt_channel_i.address[MEM_ADDR_BITS+1:2]] <= wt_channel_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_count_q <= '0;
            wb_done_o  <= 1'b0;
            wt_done_o  <= 1'b0;
        end else begin
            wt_done_o <= wt_channel_i.request;                  // Single writes finish next cycle.
            wb_done_o <= wb_channel_i.request && (wb_count_q == '1);
            if (wb_channel_i.request) begin
                wb_count_q <= wb_count_q + 1'b1;                // Wraps back to zero after a full block.
            end
        end
    end

endmodule : memory_controller

// File: source/store_controller.sv
module store_controller
    import dcache_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,

    input  logic           request_i,
    input  data_word_t     address_i,
    input  data_word_t     data_i,
    output logic           done_o,

    input  cache_port_t    load_port_i,
    output cache_port_t    cache_port_o,
    input  logic           cache_hit_i,

    output store_channel_t wt_channel_o,
    input  logic           wt_done_i
);

    typedef enum logic [1:0] {IDLE, LOOKUP, WRITE_THROUGH} store_state_t;

    store_state_t   state_q, state_d;
    data_word_t     address_q;
    data_word_t     data_q;
    cache_address_u store_addr;

    assign store_addr.raw = address_q;

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && request_i) begin
            address_q <= address_i;                             // Held until the store completes.
            data_q    <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        cache_port_o = '0;
        done_o       = 1'b0;

        // Memory takes word addresses, so the byte bits are cleared.
        wt_channel_o.request = 1'b0;
        wt_channel_o.address = {store_addr.fields.tag, store_addr.fields.index,
                                store_addr.fields.offset, {BYTE_BITS{1'b0}}};
        wt_channel_o.data    = data_q;

        case (state_q)
            IDLE: begin
                cache_port_o = load_port_i;                     // The load side owns the array when idle.
                if (request_i) begin
                    cache_port_o         = '0;
                    cache_port_o.read    = '1;
                    cache_port_o.address = address_i;
                    state_d              = LOOKUP;
                end
            end

            LOOKUP: begin
                cache_port_o.address = address_q;
                if (cache_hit_i) begin
                    cache_port_o.write  = '1;                   // Tag, status and data are all rewritten.
                    cache_port_o.data   = data_q;
                    cache_port_o.status = '{valid: 1'b1, dirty: 1'b1};
                    done_o              = 1'b1;
                    state_d             = IDLE;
                end else begin
                    wt_channel_o.request = 1'b1;                // No allocation on a store miss.
                    state_d              = WRITE_THROUGH;
                end
            end

            WRITE_THROUGH: begin
                if (wt_done_i) begin
                    done_o  = 1'b1;
                    state_d = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase
    end

endmodule : store_controller

// File: tb.f
common/dcache_pkg.sv
load_controller/load_controller.sv
source/cache_memory.sv
source/memory_controller.sv
source/store_controller.sv
source/dcache_top.sv
tests/dcache_tb.sv

// File: tests/dcache_tb.sv
module dcache_tb
    import dcache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESPONSE_TIMEOUT = 100;                      // Cycles allowed for any valid or done.

    logic       clk;
    logic       rst_n;
    logic       load_request;
    data_word_t load_address;
    data_word_t load_data;
    logic       load_valid;
    logic       store_request;
    data_word_t store_address;
    data_word_t store_data;
    logic       store_done;

    // Which block each set holds, as the core should see it.
    logic                line_valid [SETS];
    logic [TAG_BITS-1:0] line_tag [SETS];

    dcache_top UUT (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .load_request_i  (load_request),
        .load_address_i  (load_address),
        .load_data_o     (load_data),
        .load_valid_o    (load_valid),
        .store_request_i (store_request),
        .store_address_i (store_address),
        .store_data_i    (store_data),
        .store_done_o    (store_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                                  // 10 ns period.
    end

    // ##############################
    // Reporting
    // ##############################

    task automatic halt_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input data_word_t got,
                               input data_word_t expected);
        if (got !== expected) begin
            $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, expected);
            halt_run();
        end
    endtask

    // ##############################
    // Line model
    // ##############################

    function automatic logic [INDEX_BITS-1:0] set_of(input data_word_t addr);
        return addr[OFFSET_BITS+BYTE_BITS +: INDEX_BITS];       // Set index sits above offset and byte.
    endfunction

    function automatic logic [TAG_BITS-1:0] tag_of(input data_word_t addr);
        return addr[31 -: TAG_BITS];                            // Everything above the index.
    endfunction

    function automatic bit predict_hit(input data_word_t addr);
        return line_valid[set_of(addr)] && (line_tag[set_of(addr)] == tag_of(addr));
    endfunction

    // ##############################
    // Operations
    // ##############################

    // Entered at 1 ns after an edge; returns at mid-cycle with the response seen.
    task automatic wait_response(input bit is_load, input int op_index,
                                 input data_word_t addr, output int cycles);
        int waited;
        waited = 1;
        #4;                                                     // Sample in the middle of the cycle.
        while (!(is_load ? load_valid : store_done)) begin
            if (waited >= RESPONSE_TIMEOUT) begin
                $display("TIMEOUT: %s number %0d to address %h did not end in %0d cycles",
                         is_load ? "load" : "store", op_index, addr, RESPONSE_TIMEOUT);
                halt_run();
            end
            @(posedge clk);
            #5;
            waited++;
        end
        cycles = waited;
    endtask

    task automatic run_load(input int op_index, input data_word_t addr,
                            input data_word_t expected);
        bit         hit;
        int         cycles;
        data_word_t got;
        hit          = predict_hit(addr);
        load_address = addr;
        load_request = 1'b1;
        @(posedge clk);
        #1;
        load_request = 1'b0;                                    // A request lasts one cycle only.
        wait_response(1'b1, op_index, addr, cycles);
        got = load_data;
        check_value("load_data_o", got, expected);
        if (hit) begin
            check_value("load_valid_o latency", cycles, 1);     // Hits answer on the next cycle.
        end
        line_valid[set_of(addr)] = 1'b1;                        // A load always leaves its block cached.
        line_tag[set_of(addr)]   = tag_of(addr);
        @(posedge clk);
        #1;
    endtask

    task automatic run_store(input int op_index, input data_word_t addr,
                             input data_word_t value);
        bit hit;
        int cycles;
        hit           = predict_hit(addr);
        store_address = addr;
        store_data    = value;
        store_request = 1'b1;
        @(posedge clk);
        #1;
        store_request = 1'b0;
        wait_response(1'b0, op_index, addr, cycles);
        // Misses go through memory and take one cycle more, and never allocate.
        check_value("store_done_o latency", cycles, hit ? 1 : 2);
        @(posedge clk);
        #1;
    endtask

    // ##############################
    // Trace
    // ##############################

    initial begin
        int         fd;
        int         code;
        int         count;
        int         op_index;
        string      line;
        byte        op;
        data_word_t addr;
        data_word_t value;

        rst_n         = 1'b0;
        load_request  = 1'b0;
        load_address  = '0;
        store_request = 1'b0;
        store_address = '0;
        store_data    = '0;
        op_index      = 0;
        for (int i = 0; i < SETS; i++) begin
            line_valid[i] = 1'b0;                               // Every line starts invalid.
            line_tag[i]   = '0;
        end

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        fd = $fopen("tests/dcache_trace.txt", "r");
        if (fd == 0) begin
            $display("The trace file tests/dcache_trace.txt could not be opened.");
            halt_run();
        end

        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) begin
                break;
            end
            if (line.len() < 2 || line[0] == "#") begin
                continue;                                       // Blank or comment line.
            end
            count = $sscanf(line, "%c %h %h", op, addr, value);
            if (count != 3) begin
                $display("Trace line could not be read: %s", line);
                halt_run();
            end
            op_index++;
            if (op == "L") begin
                run_load(op_index, addr, value);
            end else if (op == "S") begin
                run_store(op_index, addr, value);
            end else begin
                $display("Trace operation %0d has an unknown kind '%c'.", op_index, op);
                halt_run();
            end
        end
        $fclose(fd);

        if (op_index == 0) begin
            $display("The trace held no operations.");
            halt_run();
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule : dcache_tb

// File: tests/dcache_trace.txt
# Columns: operation (L load, S store), word address in hex, then data in hex.
# For a store the data is written; for a load it is the value the load must return.
L 00000004 00000000
L 00000008 00000000
S 00000008 a5a50008
L 00000008 a5a50008
S 00000024 12345678
L 00000024 12345678
L 00000020 00000000
S 0000000c c0ffee0c
S 00000104 b1040104
L 0000010c 00000000
L 00000104 b1040104
L 00000008 a5a50008
L 0000000c c0ffee0c
S 00000030 30300030
S 0000003c 3c3c003c
L 00000030 30300030
L 0000003c 3c3c003c
S 0000004c 4c4c004c
L 0000004c 4c4c004c
L 00000250 00000000
S 00000254 25402540
L 00000058 00000000
S 00000058 05805800
L 00000254 25402540
L 00000058 05805800
L 00000ffc 00000000
S 00000ff0 0ff00ff0
L 00000ff0 0ff00ff0
